// ==== project.f ====
+incdir+include
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/fetch_req.sv
logic/fetch_queue.sv
logic/predecode.sv
logic/fetch_unit.sv
tests/fetch_assertions.sv
tests/tb_fetch_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_fetch_unit -o sim_fetch \
    || { echo "build error"; exit 1; }

./obj_dir/sim_fetch +verilator+error+limit+10 > sim.log 2>&1 || true
cat sim.log

grep -q "sim failed" sim.log && { echo "result: FAIL"; exit 1; }
grep -q "sim passed" sim.log || { echo "result: FAIL, run ended without a result"; exit 1; }
echo "result: PASS"

// ==== include/fetch_tb_defs.svh ====
`ifndef FETCH_TB_DEFS_SVH
`define FETCH_TB_DEFS_SVH

localparam int tb_seed    = 84850;
localparam int run_words  = 400;
localparam int max_cycles = 8000;

localparam logic [31:0] redir_pc_a = 32'h8000_0400;
localparam logic [31:0] redir_pc_b = 32'h8000_0800;

// planted jumps, zero where there is none
function automatic int jal_offset(input logic [31:0] addr);
    case (addr)
        32'h8000_0040: return 32'h100;
        32'h8000_0200: return -32'h180;  // back to 0x8000_0080
        32'h8000_0460: return 32'h40;
        default:       return 0;
    endcase
endfunction

function automatic logic [31:0] mem_word(input logic [31:0] addr);
    int          off;
    logic [20:0] imm;
    logic [11:0] fold;
    off  = jal_offset(addr);
    imm  = off[20:0];
    fold = addr[13:2] ^ addr[25:14] ^ {4'd0, addr[31:26], addr[1:0]};
    if (off != 0) begin
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, fetch_pkg::opc_jal};
    end
    // addi, immediate folded from every address bit
    return {fold, addr[6:2], 3'b000, addr[11:7] | 5'd1, 7'b0010011};
endfunction

`endif

// ==== tests/tb_fetch_unit.sv ====
`timescale 1ns/1ps
`include "fetch_tb_defs.svh"

module tb_fetch_unit;
    import fetch_pkg::*;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    logic [xlen-1:0]   req_addr;
    logic [tag_w-1:0]  req_tag;
    logic              resp_valid;
    logic [tag_w-1:0]  resp_tag;
    logic [xlen-1:0]   resp_data;
    logic              out_valid;
    logic [xlen-1:0]   out_pc;
    logic [xlen-1:0]   out_instr;
    logic              out_credit;
    logic              redirect_valid;
    logic [xlen-1:0]   redirect_pc;

    // memory model, requests waiting for their answer
    logic [xlen-1:0]   pend_addr [$];
    logic [tag_w-1:0]  pend_tag [$];
    int                pend_due [$];

    logic [31:0]       lcg_state;
    int                cycle;
    int                words;
    int                owed;         // credits decode still has to return
    int                credit_wait;
    int                last_jal;
    int                redirects_done;
    logic              check_failed;

    assign check_failed = i_fetch_unit.i_fetch_assertions.fail_seen;

    fetch_unit i_fetch_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .req_tag        (req_tag),
        .resp_valid     (resp_valid),
        .resp_tag       (resp_tag),
        .resp_data      (resp_data),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_instr      (out_instr),
        .out_credit     (out_credit),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'({16'd0, lcg_state[30:15]});
    endfunction

    // in order, 1 to 4 cycles, one answer per cycle
    task automatic answer_requests();
        int due;
        if (req_valid) begin
            due = cycle + 1 + next_rand() % 4;
            if (pend_due.size() > 0 && due <= pend_due[$]) begin
                due = pend_due[$] + 1;
            end
            pend_addr.push_back(req_addr);
            pend_tag.push_back(req_tag);
            pend_due.push_back(due);
        end
        resp_valid = 1'b0;
        if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
            resp_valid = 1'b1;
            resp_tag   = pend_tag.pop_front();
            resp_data  = mem_word(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end
    endtask

    task automatic return_credits();
        int r;
        out_credit = 1'b0;
        if (out_valid) begin
            words = words + 1;
            owed  = owed + 1;
            if (jal_offset(out_pc) != 0) begin
                last_jal = cycle;
            end
        end
        if (credit_wait > 0) begin
            credit_wait = credit_wait - 1;
        end else if (owed > 0) begin
            out_credit = 1'b1;
            owed       = owed - 1;
            r          = next_rand() % 16;
            if (r == 0) begin
                credit_wait = 24 + next_rand() % 16;  // long stall, queue backs up
            end else begin
                credit_wait = r % 4;
            end
        end
    endtask

    // one epoch bit, so responses from before a jal flush must be gone first
    task automatic send_redirects();
        logic quiet;
        quiet          = (cycle - last_jal) >= 16;
        redirect_valid = 1'b0;
        if (quiet && redirects_done == 0 && words >= 120) begin
            redirect_valid = 1'b1;
            redirect_pc    = redir_pc_a;
            redirects_done = 1;
        end else if (quiet && redirects_done == 1 && words >= 260) begin
            redirect_valid = 1'b1;
            redirect_pc    = redir_pc_b;
            redirects_done = 2;
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        cycle = cycle + 1;
        answer_requests();
        return_credits();
        send_redirects();
    endtask

    // a failed concurrent check ends the run right away
    initial begin
        wait (check_failed);
        $display("sim failed");
        $fatal(1, "a concurrent check failed");
    end

    initial begin
        rst_n          = 1'b0;
        resp_valid     = 1'b0;
        resp_tag       = '0;
        resp_data      = '0;
        out_credit     = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        lcg_state      = 32'(tb_seed);
        cycle          = 0;
        words          = 0;
        owed           = 0;
        credit_wait    = 0;
        last_jal       = -100;
        redirects_done = 0;

        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        while (words < run_words && cycle < max_cycles) begin
            step_cycle();
        end
        repeat (2) step_cycle();  // last word still reaches the checker

        if (words < run_words) begin
            $display("timeout: output stopped");
            $display("sim failed");
            $fatal(1, "run ended after %0d cycles with %0d words", cycle, words);
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// ==== tests/fetch_assertions.sv ====
`timescale 1ns/1ps
`include "fetch_tb_defs.svh"

module fetch_assertions (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  logic [fetch_pkg::xlen-1:0]  req_addr,
    input  logic [fetch_pkg::tag_w-1:0] req_tag,
    input  logic                        resp_valid,
    input  logic                        out_valid,
    input  logic [fetch_pkg::xlen-1:0]  out_pc,
    input  logic [fetch_pkg::xlen-1:0]  out_instr,
    input  logic                        out_credit,
    input  logic                        redirect_valid,
    input  logic [fetch_pkg::xlen-1:0]  redirect_pc
);
    import fetch_pkg::*;

    logic             fail_seen = 1'b0;  // read by the testbench top
    logic             first_req;
    logic [xlen-1:0]  exp_pc;
    logic [xlen-1:0]  exp_instr;
    logic             exp_epoch;
    logic [seq_w-1:0] last_seq;
    int               outstanding;
    int               dec_avail;

    assign exp_instr = mem_word(out_pc);

    // reference model of the fetch stream, seen only at the ports
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_req   <= 1'b1;
            exp_pc      <= reset_pc;
            exp_epoch   <= 1'b0;
            last_seq    <= '0;
            outstanding <= 0;
            dec_avail   <= dec_credits;
        end else begin
            if (req_valid) begin
                first_req <= 1'b0;
                last_seq  <= req_tag[seq_w-1:0];
            end
            outstanding <= outstanding + (req_valid ? 1 : 0) - (resp_valid ? 1 : 0);
            dec_avail   <= dec_avail + (out_credit ? 1 : 0) - (out_valid ? 1 : 0);
            // each flush seen at the ports opens a new epoch
            if (redirect_valid || (out_valid && jal_offset(out_pc) != 0)) begin
                exp_epoch <= ~exp_epoch;
            end
            if (redirect_valid) begin
                exp_pc <= redirect_pc;  // execute redirect wins
            end else if (out_valid && jal_offset(out_pc) != 0) begin
                exp_pc <= out_pc + 32'(jal_offset(out_pc));
            end else if (out_valid) begin
                exp_pc <= out_pc + 32'd4;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !req_valid && !out_valid)
        else begin
            fail_seen = 1'b1;
            $error("ERR %0t: req_valid or out_valid high during reset", $time);
        end

    first_addr: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && first_req |-> req_addr == reset_pc)
        else begin
            fail_seen = 1'b1;
            $error("ERR %0t: first req_addr %h, expected %h", $time, req_addr, reset_pc);
        end

    tag_epoch: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> req_tag[epoch_bit] == exp_epoch)
        else begin
            fail_seen = 1'b1;
            $error("ERR %0t: req_tag %h, expected epoch %0b", $time, req_tag, exp_epoch);
        end

    tag_seq: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !first_req |-> req_tag[seq_w-1:0] == last_seq + seq_w'(1))
        else begin
            fail_seen = 1'b1;
            $error("ERR %0t: req_tag %h, sequence does not follow %0d",
                   $time, req_tag, last_seq);
        end

    // sequential, jal and redirect order all in one
    pc_order: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_pc == exp_pc)
        else begin
            fail_seen = 1'b1;
            $error("ERR %0t: out_pc %h, expected %h", $time, out_pc, exp_pc);
        end

    instr_match: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_instr == exp_instr)
        else begin
            fail_seen = 1'b1;
            $error("ERR %0t: out_instr %h at pc %h, expected %h",
                   $time, out_instr, out_pc, exp_instr);
        end

    mem_limit: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding <= mem_credits)
        else begin
            fail_seen = 1'b1;
            $error("ERR %0t: %0d requests outstanding", $time, outstanding);
        end

    dec_limit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> dec_avail > 0)
        else begin
            fail_seen = 1'b1;
            $error("ERR %0t: out_valid without a decode credit", $time);
        end

endmodule

bind fetch_unit fetch_assertions i_fetch_assertions (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req_addr       (req_addr),
    .req_tag        (req_tag),
    .resp_valid     (resp_valid),
    .out_valid      (out_valid),
    .out_pc         (out_pc),
    .out_instr      (out_instr),
    .out_credit     (out_credit),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
);

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    // instruction memory
    output logic                         req_valid,
    output logic [fetch_pkg::xlen-1:0]   req_addr,
    output logic [fetch_pkg::tag_w-1:0]  req_tag,
    input  logic                         resp_valid,
    input  logic [fetch_pkg::tag_w-1:0]  resp_tag,
    input  logic [fetch_pkg::xlen-1:0]   resp_data,
    // decode
    output logic                         out_valid,
    output logic [fetch_pkg::xlen-1:0]   out_pc,
    output logic [fetch_pkg::xlen-1:0]   out_instr,
    input  logic                         out_credit,
    // execute redirect
    input  logic                         redirect_valid,
    input  logic [fetch_pkg::xlen-1:0]   redirect_pc
);
    import fetch_pkg::*;

    logic [xlen-1:0]  fetch_pc;
    logic             epoch;
    logic             issue;
    logic             flush;
    logic [xlen-1:0]  new_pc;
    logic             wr_valid;
    logic [xlen-1:0]  wr_pc;
    logic [xlen-1:0]  wr_instr;
    logic [cnt_w-1:0] occupancy;
    logic             jal_hit;
    logic [xlen-1:0]  jal_target;

    // execute redirect wins over a jal in the same cycle
    assign flush  = redirect_valid || jal_hit;
    assign new_pc = redirect_valid ? redirect_pc : jal_target;

    pc_gen i_pc_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .flush    (flush),
        .new_pc   (new_pc),
        .fetch_pc (fetch_pc),
        .epoch    (epoch)
    );

    fetch_req i_fetch_req (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_pc   (fetch_pc),
        .epoch      (epoch),
        .flush      (flush),
        .occupancy  (occupancy),
        .resp_valid (resp_valid),
        .resp_tag   (resp_tag),
        .resp_data  (resp_data),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_tag    (req_tag),
        .issue      (issue),
        .wr_valid   (wr_valid),
        .wr_pc      (wr_pc),
        .wr_instr   (wr_instr)
    );

    fetch_queue i_fetch_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .wr_valid   (wr_valid),
        .wr_pc      (wr_pc),
        .wr_instr   (wr_instr),
        .out_credit (out_credit),
        .occupancy  (occupancy),
        .head_pc    (),  // head view not needed at this level
        .head_instr (),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_instr  (out_instr)
    );

    predecode i_predecode (
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_instr  (out_instr),
        .jal_hit    (jal_hit),
        .jal_target (jal_target)
    );

endmodule

// ==== logic/predecode.sv ====
`timescale 1ns/1ps

module predecode (
    input  logic                       out_valid,
    input  logic [fetch_pkg::xlen-1:0] out_pc,
    input  logic [fetch_pkg::xlen-1:0] out_instr,
    output logic                       jal_hit,
    output logic [fetch_pkg::xlen-1:0] jal_target
);
    import fetch_pkg::*;

    instr_u          word;
    logic [xlen-1:0] j_imm;

    assign word = instr_u'(out_instr);

    assign jal_hit = out_valid && (word.base.opcode == opc_jal);

    // imm[20|10:1|11|19:12], bit 0 is always zero
    assign j_imm = {{11{word.j.imm20}},
                    word.j.imm20,
                    word.j.imm19_12,
                    word.j.imm11,
                    word.j.imm10_1,
                    1'b0};

    assign jal_target = out_pc + j_imm;

endmodule

// ==== logic/fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         wr_valid,
    input  logic [fetch_pkg::xlen-1:0]   wr_pc,
    input  logic [fetch_pkg::xlen-1:0]   wr_instr,
    input  logic                         out_credit,
    output logic [fetch_pkg::cnt_w-1:0]  occupancy,
    output logic [fetch_pkg::xlen-1:0]   head_pc,
    output logic [fetch_pkg::xlen-1:0]   head_instr,
    output logic                         out_valid,
    output logic [fetch_pkg::xlen-1:0]   out_pc,
    output logic [fetch_pkg::xlen-1:0]   out_instr
);
    import fetch_pkg::*;

    logic [xlen-1:0]   pc_mem    [queue_depth];
    logic [xlen-1:0]   instr_mem [queue_depth];
    logic [qptr_w-1:0] wr_ptr;
    logic [qptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0]  dec_cnt;
    logic              push;
    logic              pop;

    // slots were reserved at issue, so a push never finds the queue full
    assign push = wr_valid && !flush;
    assign pop  = (occupancy != '0) && (dec_cnt != '0) && !flush;

    assign head_pc    = pc_mem[rd_ptr];
    assign head_instr = instr_mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else if (flush) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + qptr_w'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + qptr_w'(1);
            end
            occupancy <= occupancy + cnt_w'(push) - cnt_w'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]    <= wr_pc;
            instr_mem[wr_ptr] <= wr_instr;
        end
    end

    // decode credits survive a flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_cnt <= cnt_w'(dec_credits);
        end else begin
            dec_cnt <= dec_cnt - cnt_w'(pop) + cnt_w'(out_credit);
        end
    end

    // output stage, valid for exactly one cycle per pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;  // pop is already low on flush
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_pc    <= head_pc;
            out_instr <= head_instr;
        end
    end

endmodule

// ==== logic/fetch_req.sv ====
`timescale 1ns/1ps

module fetch_req (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [fetch_pkg::xlen-1:0]   fetch_pc,
    input  logic                         epoch,
    input  logic                         flush,
    input  logic [fetch_pkg::cnt_w-1:0]  occupancy,
    input  logic                         resp_valid,
    input  logic [fetch_pkg::tag_w-1:0]  resp_tag,
    input  logic [fetch_pkg::xlen-1:0]   resp_data,
    output logic                         req_valid,
    output logic [fetch_pkg::xlen-1:0]   req_addr,
    output logic [fetch_pkg::tag_w-1:0]  req_tag,
    output logic                         issue,
    output logic                         wr_valid,
    output logic [fetch_pkg::xlen-1:0]   wr_pc,
    output logic [fetch_pkg::xlen-1:0]   wr_instr
);
    import fetch_pkg::*;

    logic [cnt_w-1:0] credits;
    logic [cnt_w-1:0] in_flight;
    logic [cnt_w:0]   reserved;
    logic [seq_w-1:0] seq;
    logic [seq_w-1:0] resp_seq;

    // pc per sequence number, read back when the word returns
    logic [xlen-1:0] pc_table [2**seq_w];

    assign in_flight = cnt_w'(mem_credits) - credits;
    // every outstanding request holds a queue slot
    assign reserved = {1'b0, in_flight} + {1'b0, occupancy};

    assign issue = (credits != '0)
                && (reserved < (cnt_w + 1)'(queue_depth))
                && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= cnt_w'(mem_credits);
        end else begin
            case ({issue, resp_valid})
                2'b10:   credits <= credits - cnt_w'(1);
                2'b01:   credits <= credits + cnt_w'(1);
                default: credits <= credits;  // none, or one out and one back
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
            seq       <= '0;
        end else begin
            req_valid <= issue;  // one pulse per issue
            if (issue) begin
                seq <= seq + seq_w'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr       <= fetch_pc;
            req_tag        <= {epoch, seq};
            pc_table[seq]  <= fetch_pc;
        end
    end

    // responses come back in order, only the epoch bit matters
    assign resp_seq = resp_tag[seq_w-1:0];
    assign wr_valid = resp_valid && (resp_tag[epoch_bit] == epoch);
    assign wr_pc    = pc_table[resp_seq];
    assign wr_instr = resp_data;

endmodule

// ==== logic/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       issue,   // request leaves this cycle
    input  logic                       flush,
    input  logic [fetch_pkg::xlen-1:0] new_pc,
    output logic [fetch_pkg::xlen-1:0] fetch_pc,
    output logic                       epoch
);
    import fetch_pkg::*;

    logic [xlen-1:0] seq_pc;

    assign seq_pc = fetch_pc + xlen'(4);

    // redirect beats sequential advance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc <= reset_pc;
        end else if (flush) begin
            fetch_pc <= new_pc;
        end else if (issue) begin
            fetch_pc <= seq_pc;
        end
    end

    // every flush opens a new epoch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            epoch <= 1'b0;
        end else if (flush) begin
            epoch <= ~epoch;
        end
    end

endmodule

// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // flow control
    localparam int mem_credits = 4;
    localparam int queue_depth = 4;
    localparam int dec_credits = 2;
    localparam int cnt_w = 3;  // counters span 0..4
    localparam int qptr_w = $clog2(queue_depth);

    // tag layout, epoch on top of the sequence number
    localparam int tag_w = 4;
    localparam int seq_w = 3;
    localparam int epoch_bit = 3;

    localparam logic [6:0] opc_jal = 7'b1101111;

    // one fetched word, read as base format or as J-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } base;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

endpackage
